/* build.f */
design/tape_pkg.sv
design/tape_store.sv
design/tape_transport.sv
design/tape_ce_gen.sv
design/tape_top.sv
tb/tape_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the tape controller testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module tape_tb -o tape_sim &&
out=$(./obj_dir/tape_sim) &&
echo "$out" &&
echo "$out" | grep -q "All tests passed" &&
echo "Simulation PASS" ||
{ echo "Simulation FAIL"; exit 1; }

/* tb/tape_tb.sv */
//================================================
// Directed testbench for the tape controller.
// Inputs change 1 ns after the rising edge and
// outputs are checked at that same point.
// Tape bytes come from $urandom, seed 62.
//================================================
`timescale 1ns/10ps
`default_nettype none

module tape_tb;
	import tape_pkg::*;

	localparam int TAPE_BYTES  = 64;
	localparam int ACK_TIMEOUT = 20;

	logic       clk_sys = 1'b0;
	logic       RESET;
	logic       download_i;
	logic       load_stb_i;
	tape_byte_t load_data_i;
	logic       key_stb_i;
	key_code_t  key_code_i;
	logic       key_press_i;
	logic       stop_i;
	logic       loop_start_i;
	logic       loop_next_i;
	logic       tape_req_i;
	cpu_speed_t cpu_speed_i;
	logic       mem_wait_i;
	tape_byte_t tape_data_o;
	logic       tape_ack_o;
	logic       motor_o;
	logic       ready_o;
	logic       tape_ce_o;

	tape_byte_t tape_bytes[$];
	int         err_cnt = 0;
	int         test_cnt = 0;
	int         test_fail_cnt = 0;
	int         test_first_err = 0;

	always #5 clk_sys = ~clk_sys;

	tape_top i_dut (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.download_i   (download_i),
		.load_stb_i   (load_stb_i),
		.load_data_i  (load_data_i),
		.key_stb_i    (key_stb_i),
		.key_code_i   (key_code_i),
		.key_press_i  (key_press_i),
		.stop_i       (stop_i),
		.loop_start_i (loop_start_i),
		.loop_next_i  (loop_next_i),
		.tape_req_i   (tape_req_i),
		.cpu_speed_i  (cpu_speed_i),
		.mem_wait_i   (mem_wait_i),
		.tape_data_o  (tape_data_o),
		.tape_ack_o   (tape_ack_o),
		.motor_o      (motor_o),
		.ready_o      (ready_o),
		.tape_ce_o    (tape_ce_o)
	);

	// Just after the next rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic expect_transport(input int exp_motor, input int exp_ready);
		check_value("motor_o", int'(motor_o), exp_motor);
		check_value("ready_o", int'(ready_o), exp_ready);
	endtask

	task automatic begin_test();
		test_cnt++;
		test_first_err = err_cnt;
	endtask

	task automatic report_test(input string name);
		if (err_cnt == test_first_err) begin
			$display("Test %0d %s: ok", test_cnt, name);
		end else begin
			$display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - test_first_err);
			test_fail_cnt++;
		end
	endtask

	// Loads a new random tape image
	// Playback starts one cycle after download_i falls
	task automatic download_tape();
		tape_bytes.delete();
		repeat (TAPE_BYTES) tape_bytes.push_back(tape_byte_t'($urandom));
		download_i = 1'b1;
		next_cycle();
		foreach (tape_bytes[i]) begin
			load_stb_i  = 1'b1;
			load_data_i = tape_bytes[i];
			next_cycle();
		end
		load_stb_i = 1'b0;
		download_i = 1'b0;
		next_cycle();
		expect_transport(1, 1);
	endtask

	// One player request with the ack expected two cycles after the toggle
	task automatic read_byte(input int index);
		int cycles;
		cycles     = 0;
		tape_req_i = !tape_req_i;
		while (tape_ack_o != tape_req_i && cycles < ACK_TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		assert (tape_ack_o == tape_req_i) else begin
			$display("Timeout at %0t ns: no tape_ack_o toggle within %0d cycles",
				$time, ACK_TIMEOUT);
			err_cnt++;
		end
		if (tape_ack_o == tape_req_i) begin
			check_value("tape_ack_o latency", cycles, 2);
			check_value("tape_data_o", int'(tape_data_o), int'(tape_bytes[index]));
		end
	endtask

	task automatic send_key(input key_code_t code, input logic press);
		key_code_i  = code;
		key_press_i = press;
		key_stb_i   = 1'b1;
		next_cycle();
		key_stb_i   = 1'b0;
	endtask

	task automatic count_ce_pulses(input string label, input cpu_speed_t speed,
		input logic hold_wait, input int exp);
		int count;
		count       = 0;
		cpu_speed_i = speed;
		mem_wait_i  = hold_wait;
		// Let the divider wrap so the new speed is taken
		repeat (64) next_cycle();
		repeat (128) begin
			next_cycle();
			if (tape_ce_o) begin
				count++;
			end
		end
		check_value({"tape_ce_o pulses at ", label}, count, exp);
	endtask

	//================================================
	// Directed tests
	//================================================
	task automatic reset_and_download();
		begin_test();
		RESET = 1'b1;
		repeat (5) next_cycle();
		expect_transport(0, 0);
		check_value("tape_ce_o", int'(tape_ce_o), 0);
		RESET = 1'b0;
		repeat (4) begin
			next_cycle();
			expect_transport(0, 0);
		end
		download_tape();
		report_test("reset and download");
	endtask

	task automatic sequential_read();
		begin_test();
		for (int i = 0; i < TAPE_BYTES; i++) begin
			check_value("ready_o", int'(ready_o), 1);
			read_byte(i);
		end
		// End of tape after the last byte
		expect_transport(0, 0);
		report_test("sequential read");
	endtask

	task automatic key_commands();
		begin_test();
		download_tape();
		send_key(KEY_PLAY_PAUSE, 1'b1);
		expect_transport(0, 1);
		send_key(KEY_PLAY_PAUSE, 1'b0);
		expect_transport(0, 1);
		send_key(KEY_PLAY_PAUSE, 1'b1);
		expect_transport(1, 1);
		for (int i = 0; i < 3; i++) begin
			read_byte(i);
		end
		send_key(KEY_RESTART, 1'b1);
		expect_transport(0, 1);
		send_key(KEY_PLAY_PAUSE, 1'b1);
		expect_transport(1, 1);
		read_byte(0);
		send_key(KEY_EJECT, 1'b1);
		check_value("ready_o", int'(ready_o), 0);
		report_test("keys");
	endtask

	task automatic player_status();
		begin_test();
		download_tape();
		stop_i = 1'b1;
		next_cycle();
		stop_i = 1'b0;
		expect_transport(0, 1);
		send_key(KEY_PLAY_PAUSE, 1'b1);
		expect_transport(1, 1);
		for (int i = 0; i < 10; i++) begin
			read_byte(i);
		end
		loop_start_i = 1'b1;
		next_cycle();
		loop_start_i = 1'b0;
		read_byte(10);
		read_byte(11);
		loop_next_i = 1'b1;
		next_cycle();
		loop_next_i = 1'b0;
		read_byte(10);
		report_test("player status");
	endtask

	task automatic clock_enable_rates();
		begin_test();
		count_ce_pulses("SPEED_3M5", SPEED_3M5, 1'b0, 4);
		count_ce_pulses("SPEED_7M", SPEED_7M, 1'b0, 8);
		count_ce_pulses("SPEED_14M", SPEED_14M, 1'b0, 16);
		count_ce_pulses("SPEED_28M", SPEED_28M, 1'b0, 32);
		// Wait only gates the two fast speeds
		count_ce_pulses("SPEED_7M with wait", SPEED_7M, 1'b1, 8);
		count_ce_pulses("SPEED_14M with wait", SPEED_14M, 1'b1, 0);
		count_ce_pulses("SPEED_28M with wait", SPEED_28M, 1'b1, 0);
		mem_wait_i = 1'b0;
		report_test("clock enable");
	endtask

	initial begin
		void'($urandom(62));
		RESET        = 1'b1;
		download_i   = 1'b0;
		load_stb_i   = 1'b0;
		load_data_i  = '0;
		key_stb_i    = 1'b0;
		key_code_i   = '0;
		key_press_i  = 1'b0;
		stop_i       = 1'b0;
		loop_start_i = 1'b0;
		loop_next_i  = 1'b0;
		tape_req_i   = 1'b0;
		cpu_speed_i  = SPEED_3M5;
		mem_wait_i   = 1'b0;
		reset_and_download();
		sequential_read();
		key_commands();
		player_status();
		clock_enable_rates();
		$display("Summary: %0d tests run, %0d tests failed, %0d checks failed",
			test_cnt, test_fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/tape_top.sv */
//================================================
// Tape playback controller on one clock.
// A toggle on tape_req_i is answered by a toggle
// on tape_ack_o two cycles later, with the byte
// on tape_data_o. One request in flight at most.
//================================================
`timescale 1ns/10ps
`default_nettype none

module tape_top (
	input  wire                  clk_sys,
	input  wire                  RESET,
	input  wire                  download_i,
	input  wire                  load_stb_i,
	input  wire tape_pkg::tape_byte_t load_data_i,
	input  wire                  key_stb_i,
	input  wire tape_pkg::key_code_t key_code_i,
	input  wire                  key_press_i,
	input  wire                  stop_i,
	input  wire                  loop_start_i,
	input  wire                  loop_next_i,
	input  wire                  tape_req_i,
	input  wire tape_pkg::cpu_speed_t cpu_speed_i,
	input  wire                  mem_wait_i,
	output tape_pkg::tape_byte_t tape_data_o,
	output logic                 tape_ack_o,
	output logic                 motor_o,
	output logic                 ready_o,
	output logic                 tape_ce_o
);
	import tape_pkg::*;

	logic       wr_en;
	tape_addr_t wr_addr;
	logic       rd_stb;
	tape_addr_t rd_addr;

	tape_transport i_transport (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.download_i   (download_i),
		.load_stb_i   (load_stb_i),
		.key_stb_i    (key_stb_i),
		.key_code_i   (key_code_i),
		.key_press_i  (key_press_i),
		.stop_i       (stop_i),
		.loop_start_i (loop_start_i),
		.loop_next_i  (loop_next_i),
		.tape_req_i   (tape_req_i),
		.wr_en_o      (wr_en),
		.wr_addr_o    (wr_addr),
		.rd_stb_o     (rd_stb),
		.rd_addr_o    (rd_addr),
		.motor_o      (motor_o),
		.ready_o      (ready_o)
	);

	// Load data bypasses the transport
	tape_store i_store (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (load_data_i),
		.rd_stb_i  (rd_stb),
		.rd_addr_i (rd_addr),
		.rd_data_o (tape_data_o),
		.ack_o     (tape_ack_o)
	);

	tape_ce_gen i_ce_gen (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cpu_speed_i (cpu_speed_i),
		.mem_wait_i  (mem_wait_i),
		.tape_ce_o   (tape_ce_o)
	);

endmodule

`default_nettype wire

/* design/tape_ce_gen.sv */
//================================================
// Tape clock enable. One pulse per 32, 16, 8 or 4
// cycles for the four CPU speeds. The speed is
// taken only when the divider wraps. At 14 and 28
// MHz a pending memory wait drops the pulse.
//================================================
`timescale 1ns/10ps
`default_nettype none

module tape_ce_gen (
	input  wire                  clk_sys,
	input  wire                  RESET,
	input  wire tape_pkg::cpu_speed_t cpu_speed_i,
	input  wire                  mem_wait_i,
	output logic                 tape_ce_o
);
	import tape_pkg::*;

	logic [CE_DIV_W-1:0] div;
	cpu_speed_t          speed_q;
	logic                ce_next;

	// Fewer low bits must be zero at higher speeds
	always_comb begin
		case (speed_q)
			SPEED_3M5: ce_next = (div[4:0] == '0);
			SPEED_7M:  ce_next = (div[3:0] == '0);
			SPEED_14M: ce_next = (div[2:0] == '0) && !mem_wait_i;
			default:   ce_next = (div[1:0] == '0) && !mem_wait_i;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			div       <= '0;
			speed_q   <= SPEED_3M5;
			tape_ce_o <= 1'b0;
		end else begin
			div       <= div + 1'b1;
			tape_ce_o <= ce_next;
			if (&div) begin
				speed_q <= cpu_speed_i;
			end
		end
	end

endmodule

`default_nettype wire

/* design/tape_transport.sv */
//================================================
// Tape transport control. Counts download bytes,
// handles the play/pause, restart and eject keys,
// serves toggled player requests and tracks the
// loop point and the end of the tape.
// Requests are held off, not lost, while a
// download or a restart is in progress.
//================================================
`timescale 1ns/10ps
`default_nettype none

module tape_transport (
	input  wire                  clk_sys,
	input  wire                  RESET,
	input  wire                  download_i,
	input  wire                  load_stb_i,
	input  wire                  key_stb_i,
	input  wire tape_pkg::key_code_t key_code_i,
	input  wire                  key_press_i,
	input  wire                  stop_i,
	input  wire                  loop_start_i,
	input  wire                  loop_next_i,
	input  wire                  tape_req_i,
	output logic                 wr_en_o,
	output tape_pkg::tape_addr_t wr_addr_o,
	output logic                 rd_stb_o,
	output tape_pkg::tape_addr_t rd_addr_o,
	output logic                 motor_o,
	output logic                 ready_o
);
	import tape_pkg::*;

	tape_addr_t wr_cnt;
	tape_addr_t tape_len;
	tape_addr_t rd_ptr;
	tape_addr_t rd_ptr_next;
	tape_addr_t loop_addr;
	logic       req_copy;
	logic       ready_q;
	logic       pause_q;
	logic       old_download;
	logic       download_end;
	logic       key_play;
	logic       key_restart;
	logic       key_eject;
	logic       req_serve;

	// Key decode, play/pause acts on press only
	assign key_play    = key_stb_i && key_press_i && (key_code_i == KEY_PLAY_PAUSE);
	assign key_restart = key_stb_i && (key_code_i == KEY_RESTART);
	assign key_eject   = key_stb_i && (key_code_i == KEY_EJECT);

	assign download_end = old_download && !download_i;
	assign rd_ptr_next  = rd_ptr + 1'b1;

	// New request when the player toggle differs from our copy
	assign req_serve = (tape_req_i != req_copy) && !download_i && !key_restart;

	// Download bytes go straight to the store
	assign wr_en_o   = download_i && load_stb_i;
	assign wr_addr_o = wr_cnt;

	assign motor_o = !pause_q;
	assign ready_o = ready_q;

	//================================================
	// Transport state
	//================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			wr_cnt       <= '0;
			tape_len     <= '0;
			rd_ptr       <= '0;
			loop_addr    <= '0;
			req_copy     <= 1'b0;
			ready_q      <= 1'b0;
			pause_q      <= 1'b1;
			rd_stb_o     <= 1'b0;
		end else begin
			old_download <= download_i;
			rd_stb_o     <= 1'b0;

			// Write counter restarts at zero for every download
			if (!download_i) begin
				wr_cnt <= '0;
			end else if (load_stb_i) begin
				wr_cnt <= wr_cnt + 1'b1;
			end

			if (key_play) begin
				pause_q <= !pause_q;
			end
			if (key_eject) begin
				ready_q <= 1'b0;
				pause_q <= 1'b1;
			end
			if (!ready_q) begin
				pause_q <= 1'b1;
			end

			if (download_i || key_restart) begin
				// Rewind, download also drops the old tape
				rd_ptr  <= '0;
				pause_q <= 1'b1;
				if (download_i) begin
					ready_q <= 1'b0;
				end
			end else if (req_serve) begin
				req_copy <= tape_req_i;
				rd_stb_o <= 1'b1;
				rd_ptr   <= rd_ptr_next;
				// Last byte handed out
				if (rd_ptr_next >= tape_len) begin
					ready_q <= 1'b0;
					pause_q <= 1'b1;
				end
			end

			// Player status strobes
			if (stop_i) begin
				pause_q <= 1'b1;
			end
			if (loop_start_i) begin
				loop_addr <= rd_ptr;
			end
			if (loop_next_i) begin
				rd_ptr <= loop_addr;
			end

			// Download finished, tape is ready and starts playing
			if (download_end) begin
				tape_len <= wr_cnt;
				ready_q  <= 1'b1;
				pause_q  <= 1'b0;
			end
		end
	end

	// Read address for the store, valid with rd_stb_o
	always_ff @(posedge clk_sys) begin
		if (req_serve) begin
			rd_addr_o <= rd_ptr;
		end
	end

endmodule

`default_nettype wire

/* design/tape_store.sv */
//================================================
// On-chip tape image store. Writes land in the
// cycle of their enable. Each read strobe returns
// the byte one cycle later and inverts ack_o.
// A read and write to one address in the same
// cycle returns the old byte.
//================================================
`timescale 1ns/10ps
`default_nettype none

module tape_store (
	input  wire                  clk_sys,
	input  wire                  RESET,
	input  wire                  wr_en_i,
	input  wire tape_pkg::tape_addr_t wr_addr_i,
	input  wire tape_pkg::tape_byte_t wr_data_i,
	input  wire                  rd_stb_i,
	input  wire tape_pkg::tape_addr_t rd_addr_i,
	output tape_pkg::tape_byte_t rd_data_o,
	output logic                 ack_o
);
	import tape_pkg::*;

	tape_byte_t mem [TAPE_DEPTH];

	// Download port
	always_ff @(posedge clk_sys) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// Registered read for the player
	always_ff @(posedge clk_sys) begin
		if (rd_stb_i) begin
			rd_data_o <= mem[rd_addr_i];
		end
	end

	// Ack toggles together with the data update
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ack_o <= 1'b0;
		end else if (rd_stb_i) begin
			ack_o <= !ack_o;
		end
	end

endmodule

`default_nettype wire

/* design/tape_pkg.sv */
//================================================
// Shared widths, key codes and types of the tape
// playback path. One tape image is held on chip.
// Tape length is kept in TAPE_ADDR_W bits, so an
// image must be shorter than TAPE_DEPTH bytes.
//================================================
`default_nettype none

package tape_pkg;

	// Store geometry
	localparam int TAPE_ADDR_W = 12;
	localparam int TAPE_DEPTH  = 1 << TAPE_ADDR_W;

	typedef logic [TAPE_ADDR_W-1:0] tape_addr_t;
	typedef logic [7:0]             tape_byte_t;

	// Scan code, extended flag in bit 8
	typedef logic [8:0] key_code_t;

	// F5 toggles play/pause, F6 rewinds, F7 ejects
	localparam key_code_t KEY_PLAY_PAUSE = 9'h003;
	localparam key_code_t KEY_RESTART    = 9'h00B;
	localparam key_code_t KEY_EJECT      = 9'h083;

	// CPU speed setting as seen by the tape clock
	typedef enum logic [1:0] {
		SPEED_3M5 = 2'd0,
		SPEED_7M  = 2'd1,
		SPEED_14M = 2'd2,
		SPEED_28M = 2'd3
	} cpu_speed_t;

	// Tape clock divider width
	localparam int CE_DIV_W = 5;

endpackage

`default_nettype wire
